/* vlog.f */
rtl/audio_pkg.sv
rtl/audio_regs.sv
rtl/dma_arbiter.sv
rtl/channel_fetch.sv
rtl/sample_fifo.sv
rtl/channel_mixer.sv
rtl/audio_controller.sv
test/audio_controller_assertions.sv
test/audio_controller_tb.sv

/* Makefile */
SIM := obj_dir/Vaudio_controller_tb

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log || (echo "Simulation ended without a result"; exit 1)

$(SIM): vlog.f $(wildcard rtl/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module audio_controller_tb \
		-o Vaudio_controller_tb -f vlog.f

clean:
	rm -rf obj_dir sim.log

/* test/audio_controller_tb.sv */
/*
 Testbench for the audio playback controller.
 Sets up channels over the CPU port, answers DMA requests from a memory
 model with random latency, strobes the mixer and checks every output
 frame, the busy readback and the DMA address order.
*/

`timescale 1ns/100ps

module audio_controller_tb;

	// Words fetched over all tests: 8 + 6 + 36 + 19
	localparam int frame_total = 69;
	localparam int timeout_cycles = 50 * frame_total + 500;

	logic i_clock;
	logic i_rst_n;
	audio_pkg::cpu_req_t cpu;
	audio_pkg::data_t cpu_rdata;
	logic cpu_ready;
	audio_pkg::dma_req_t dma;
	logic dma_ready;
	audio_pkg::data_t dma_rdata;
	logic sample_strobe;
	audio_pkg::stereo_frame_t sample;

	// Expected setup of the running test
	audio_pkg::addr_t cfg_base [audio_pkg::num_channels];
	int cfg_count [audio_pkg::num_channels];
	int cfg_vol [audio_pkg::num_channels];
	audio_pkg::addr_t exp_addr [audio_pkg::num_channels];
	int served [audio_pkg::num_channels];

	logic replace_armed;
	audio_pkg::addr_t replace_base;
	int stale_count;

	string test_name = "reset";
	int checks = 0;
	int errors = 0;
	int cycle_count = 0;
	int frame_idx = 0;
	logic check_mix = 1'b0;
	logic strobe_seen = 1'b0;
	logic dma_waiting = 1'b0;
	logic [1:0] dma_delay = 2'd0;
	logic [15:0] lfsr = 16'd27219;

	audio_controller dut_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_cpu(cpu),
		.o_cpu_rdata(cpu_rdata),
		.o_cpu_ready(cpu_ready),
		.o_dma(dma),
		.i_dma_ready(dma_ready),
		.i_dma_rdata(dma_rdata),
		.i_sample_strobe(sample_strobe),
		.o_sample(sample)
	);

	always begin
		#2 i_clock = ~i_clock;
	end

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		logic fb;
		fb = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], fb};
	endfunction

	// Volume v scales by v/16 with floor, channels sum with 16-bit wrap
	function automatic audio_pkg::stereo_frame_t mix_frame(input int idx);
		audio_pkg::stereo_frame_t f;
		logic [31:0] addr;
		int word;
		int sum_l;
		int sum_r;
		sum_l = 0;
		sum_r = 0;
		for (int n = 0; n < audio_pkg::num_channels; n++) begin
			if (idx < cfg_count[n]) begin
				addr = cfg_base[n] + 32'(4 * idx);
				word = int'(addr[15:2]);
				// Inverse of a positive word is -1 - word
				sum_l = sum_l + ((word * cfg_vol[n]) >>> 4);
				sum_r = sum_r + (((-1 - word) * cfg_vol[n]) >>> 4);
			end
		end
		f.left = sum_l[15:0];
		f.right = sum_r[15:0];
		return f;
	endfunction

	task automatic check_equal(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual == expected) else begin
			errors++;
			$display("FAIL %s, %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic cpu_access(input logic rw, input audio_pkg::cpu_addr_t addr,
		input audio_pkg::data_t wdata, output audio_pkg::data_t rdata);
		cpu.request = 1'b1;
		cpu.rw = rw;
		cpu.address = addr;
		cpu.wdata = wdata;
		do begin
			@(posedge i_clock);
			#1;
		end while (!cpu_ready);
		rdata = cpu_rdata;
		cpu.request = 1'b0;
		do begin
			@(posedge i_clock);
			#1;
		end while (cpu_ready);
	endtask

	task automatic cpu_write(input audio_pkg::cpu_addr_t addr, input audio_pkg::data_t wdata);
		audio_pkg::data_t unused;
		cpu_access(1'b1, addr, wdata, unused);
	endtask

	task automatic cpu_read(input audio_pkg::cpu_addr_t addr, output audio_pkg::data_t rdata);
		cpu_access(1'b0, addr, '0, rdata);
	endtask

	task automatic clear_config();
		for (int n = 0; n < audio_pkg::num_channels; n++) begin
			cfg_base[n] = '0;
			cfg_count[n] = 0;
			cfg_vol[n] = 0;
			exp_addr[n] = '0;
			served[n] = 0;
		end
		frame_idx = 0;
		replace_armed = 1'b0;
		stale_count = 0;
	endtask

	// Count write last, it starts the channel
	task automatic setup_channel(input int ch, input audio_pkg::addr_t base, input int count,
		input int vol);
		audio_pkg::cpu_addr_t blk;
		blk = audio_pkg::cpu_addr_t'(ch * audio_pkg::reg_stride);
		cfg_base[ch] = base;
		cfg_count[ch] = count;
		cfg_vol[ch] = vol;
		exp_addr[ch] = base;
		served[ch] = 0;
		cpu_write(blk | audio_pkg::cpu_addr_t'(audio_pkg::reg_address), base);
		cpu_write(blk | audio_pkg::cpu_addr_t'(audio_pkg::reg_volume), 32'(vol));
		cpu_write(blk | audio_pkg::cpu_addr_t'(audio_pkg::reg_count), 32'(count));
	endtask

	task automatic run_strobes(input int count);
		for (int s = 0; s < count; s++) begin
			sample_strobe = 1'b1;
			@(posedge i_clock);
			#1;
			sample_strobe = 1'b0;
			repeat (31) @(posedge i_clock);
			#1;
		end
	endtask

	task automatic play(input int strobes);
		audio_pkg::data_t busy;
		logic [31:0] mask;
		mask = '0;
		for (int n = 0; n < audio_pkg::num_channels; n++) begin
			mask[n] = cfg_count[n] > 0;
		end
		cpu_read(audio_pkg::reg_busy, busy);
		check_equal("busy after start", mask, busy);
		repeat (64) @(posedge i_clock);
		#1;
		run_strobes(strobes);
		cpu_read(audio_pkg::reg_busy, busy);
		check_equal("busy after playback", '0, busy);
		for (int n = 0; n < audio_pkg::num_channels; n++) begin
			if (cfg_count[n] > 0) begin
				check_equal($sformatf("words on channel %0d", n), cfg_count[n], served[n]);
			end
		end
	endtask

	// Region of channel n is 0x(n+1)_xxxx
	task automatic record_dma(input audio_pkg::addr_t addr);
		int ch;
		logic in_region;
		ch = int'(addr[31:16]) - 1;
		in_region = 1'b0;
		if (ch >= 0 && ch < audio_pkg::num_channels) begin
			in_region = cfg_count[ch] != 0;
		end
		checks++;
		assert (in_region) else begin
			errors++;
			$display("DMA request to %h lies outside every started channel", addr);
		end
		if (in_region) begin
			if (replace_armed && ch == 0 && addr == replace_base) begin
				replace_armed = 1'b0;
				exp_addr[0] = addr + 4;
				served[0] = 1;
			end else begin
				if (replace_armed && ch == 0) begin
					stale_count++;
				end
				check_equal("DMA address", exp_addr[ch], addr);
				exp_addr[ch] = addr + 4;
				served[ch]++;
			end
		end
	endtask

	// DMA memory model, answers after 0 to 3 cycles
	always begin : dma_model
		logic [15:0] word;
		@(posedge i_clock);
		#1;
		if (dma_ready) begin
			dma_ready = 1'b0;
		end else if (dma.request) begin
			if (!dma_waiting) begin
				dma_waiting = 1'b1;
				lfsr = lfsr_next(lfsr);
				dma_delay[0] = lfsr[0];
				lfsr = lfsr_next(lfsr);
				dma_delay[1] = lfsr[0];
			end
			if (dma_delay == 2'd0) begin
				dma_waiting = 1'b0;
				word = dma.address[15:0] >> 2;
				dma_rdata = {word, ~word};
				dma_ready = 1'b1;
				record_dma(dma.address);
			end else begin
				dma_delay--;
			end
		end
	end

	// o_sample is checked on the falling edge after the strobe is taken
	always @(negedge i_clock) begin
		if (strobe_seen) begin
			check_equal($sformatf("frame %0d", frame_idx), mix_frame(frame_idx), sample);
			frame_idx++;
		end
		strobe_seen = sample_strobe && check_mix;
	end

	always @(posedge i_clock) begin
		cycle_count++;
		if (cycle_count == timeout_cycles) begin
			$display("Run did not finish within %0d cycles", timeout_cycles);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		audio_pkg::data_t rdata;
		i_clock = 1'b0;
		i_rst_n = 1'b0;
		cpu = '0;
		dma_ready = 1'b0;
		dma_rdata = '0;
		sample_strobe = 1'b0;
		clear_config();
		repeat (8) @(posedge i_clock);
		#1;
		check_equal("cpu ready", '0, 32'(cpu_ready));
		check_equal("dma request", '0, 32'(dma.request));
		check_equal("sample", '0, sample);
		i_rst_n = 1'b1;

		test_name = "register access";
		cpu_read(audio_pkg::reg_busy, rdata);
		check_equal("busy when idle", '0, rdata);
		cpu_read(8'h03, rdata);
		check_equal("unmapped read", '0, rdata);
		cpu_read(8'hf2, rdata);
		check_equal("unmapped read", '0, rdata);

		test_name = "single volume 15";
		clear_config();
		check_mix = 1'b1;
		setup_channel(0, 32'h0001_0100, 8, 15);
		play(10);

		test_name = "single volume 8";
		clear_config();
		setup_channel(2, 32'h0003_2000, 6, 8);
		play(8);

		// Large samples so both halves of the sum wrap
		test_name = "four channels";
		clear_config();
		setup_channel(0, 32'h0001_f000, 10, 15);
		setup_channel(1, 32'h0002_e000, 8, 13);
		setup_channel(2, 32'h0003_d000, 12, 11);
		setup_channel(3, 32'h0004_c000, 6, 15);
		play(14);

		test_name = "replace";
		clear_config();
		check_mix = 1'b0;
		setup_channel(0, 32'h0001_4000, 16, 15);
		repeat (64) @(posedge i_clock);
		#1;
		run_strobes(2);
		cpu_write(8'h00, 32'h0001_6000);
		// A pop right before the count write leaves a fetch in flight
		sample_strobe = 1'b1;
		@(posedge i_clock);
		#1;
		sample_strobe = 1'b0;
		replace_base = 32'h0001_6000;
		replace_armed = 1'b1;
		cfg_count[0] = 3;
		cpu_write(8'h01, 32'd3);
		rdata = 32'hffff_ffff;
		for (int i = 0; i < 16 && rdata != '0; i++) begin
			run_strobes(1);
			cpu_read(audio_pkg::reg_busy, rdata);
		end
		check_equal("busy after playback", '0, rdata);
		check_equal("new base reached", '0, 32'(replace_armed));
		check_equal("words after replace", 32'd3, served[0]);
		checks++;
		assert (stale_count <= 2) else begin
			errors++;
			$display("Channel 0 kept fetching old addresses %0d times after the replace",
				stale_count);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* test/audio_controller_assertions.sv */
/*
 Protocol assertions for the audio controller, bound into its top level.
 Watch the DMA request hold and grant-done pulses, and the CPU ready.
*/

`timescale 1ns/100ps

module audio_controller_assertions (
	input logic i_clock,
	input logic i_rst_n,
	input audio_pkg::cpu_req_t i_cpu,
	input logic i_cpu_ready,
	input audio_pkg::dma_req_t i_dma,
	input logic i_dma_ready,
	input logic [audio_pkg::num_channels-1:0] i_grant_done
);

	dma_addr_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_dma.request && !i_dma_ready |=> i_dma.request && $stable(i_dma.address))
		else $error("DMA address or request changed before the host answered");

	// One owner per answer
	grant_per_ready: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_dma_ready |-> $onehot(i_grant_done))
		else $error("DMA answer did not pulse exactly one grant-done");

	cpu_ready_needs_request: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		$rose(i_cpu_ready) |-> $past(i_cpu.request))
		else $error("CPU ready rose without a request");

endmodule

bind audio_controller audio_controller_assertions assertions_i (
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_cpu(i_cpu),
	.i_cpu_ready(o_cpu_ready),
	.i_dma(o_dma),
	.i_dma_ready(i_dma_ready),
	.i_grant_done(grant_done)
);

/* rtl/audio_controller.sv */
/*
 Top level of the multi-channel audio playback controller.
 Joins the CPU register block, one fetch and FIFO pair per channel,
 the DMA round-robin arbiter and the output mixer.
*/

`timescale 1ns/100ps

module audio_controller (
	input logic i_clock,
	input logic i_rst_n,
	input audio_pkg::cpu_req_t i_cpu,
	output audio_pkg::data_t o_cpu_rdata,
	output logic o_cpu_ready,
	output audio_pkg::dma_req_t o_dma,
	input logic i_dma_ready,
	input audio_pkg::data_t i_dma_rdata,
	input logic i_sample_strobe,
	output audio_pkg::stereo_frame_t o_sample
);

	audio_pkg::chan_setup_t setup [audio_pkg::num_channels];
	audio_pkg::volume_t volume [audio_pkg::num_channels];
	audio_pkg::dma_req_t chan_req [audio_pkg::num_channels];
	audio_pkg::stereo_frame_t fetch_frame [audio_pkg::num_channels];
	audio_pkg::stereo_frame_t fifo_frame [audio_pkg::num_channels];
	logic [audio_pkg::num_channels-1:0] grant_done;
	logic [audio_pkg::num_channels-1:0] fetch_valid;
	logic [audio_pkg::num_channels-1:0] fetch_ready;
	logic [audio_pkg::num_channels-1:0] fetch_active;
	logic [audio_pkg::num_channels-1:0] fifo_valid;
	logic [audio_pkg::num_channels-1:0] mix_ready;

	audio_regs regs_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_cpu(i_cpu),
		.o_cpu_rdata(o_cpu_rdata),
		.o_cpu_ready(o_cpu_ready),
		.o_setup(setup),
		.o_volume(volume),
		.i_fetch_active(fetch_active),
		.i_fifo_valid(fifo_valid)
	);

	dma_arbiter arbiter_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_req(chan_req),
		.o_grant_done(grant_done),
		.o_dma(o_dma),
		.i_dma_ready(i_dma_ready)
	);

	for (genvar i = 0; i < audio_pkg::num_channels; i++) begin : gen_chan
		channel_fetch fetch_i (
			.i_clock(i_clock),
			.i_rst_n(i_rst_n),
			.i_setup(setup[i]),
			.o_req(chan_req[i]),
			.i_grant_done(grant_done[i]),
			.i_dma_rdata(i_dma_rdata),
			.o_frame(fetch_frame[i]),
			.o_frame_valid(fetch_valid[i]),
			.i_frame_ready(fetch_ready[i]),
			.o_active(fetch_active[i])
		);

		sample_fifo fifo_i (
			.i_clock(i_clock),
			.i_rst_n(i_rst_n),
			.i_frame(fetch_frame[i]),
			.i_valid(fetch_valid[i]),
			.o_ready(fetch_ready[i]),
			.o_frame(fifo_frame[i]),
			.o_valid(fifo_valid[i]),
			.i_ready(mix_ready[i])
		);
	end

	channel_mixer mixer_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_sample_strobe(i_sample_strobe),
		.i_frame(fifo_frame),
		.i_valid(fifo_valid),
		.o_ready(mix_ready),
		.i_volume(volume),
		.o_sample(o_sample)
	);

endmodule

/* rtl/channel_mixer.sv */
/*
 Stereo mixer for all channels.
 On each sample strobe it pops one frame from every channel that has
 one, scales it by volume/16 and sums with 16-bit wrap into o_sample.
*/

`timescale 1ns/100ps

module channel_mixer (
	input logic i_clock,
	input logic i_rst_n,
	input logic i_sample_strobe,
	input audio_pkg::stereo_frame_t i_frame [audio_pkg::num_channels],
	input logic [audio_pkg::num_channels-1:0] i_valid,
	output logic [audio_pkg::num_channels-1:0] o_ready,
	input audio_pkg::volume_t i_volume [audio_pkg::num_channels],
	output audio_pkg::stereo_frame_t o_sample
);

	logic signed [audio_pkg::sample_width+audio_pkg::volume_width:0] prod_l;
	logic signed [audio_pkg::sample_width+audio_pkg::volume_width:0] prod_r;
	audio_pkg::sample_t sum_l;
	audio_pkg::sample_t sum_r;

	assign o_ready = {audio_pkg::num_channels{i_sample_strobe}};

	// Empty channels add nothing
	always_comb begin
		sum_l = '0;
		sum_r = '0;
		prod_l = '0;
		prod_r = '0;
		for (int i = 0; i < audio_pkg::num_channels; i++) begin
			if (i_valid[i]) begin
				prod_l = i_frame[i].left * $signed({1'b0, i_volume[i]});
				prod_r = i_frame[i].right * $signed({1'b0, i_volume[i]});
				sum_l = sum_l + audio_pkg::sample_t'(prod_l >>> 4);
				sum_r = sum_r + audio_pkg::sample_t'(prod_r >>> 4);
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_sample <= '0;
		end else if (i_sample_strobe) begin
			o_sample.left <= sum_l;
			o_sample.right <= sum_r;
		end
	end

endmodule

/* rtl/sample_fifo.sv */
/*
 Small frame FIFO between a channel's DMA fetch and the mixer.
 Push and pop both use valid/ready; o_ready is not full, o_valid is
 not empty. Depth comes from the package and must be a power of two.
*/

`timescale 1ns/100ps

module sample_fifo (
	input logic i_clock,
	input logic i_rst_n,
	input audio_pkg::stereo_frame_t i_frame,
	input logic i_valid,
	output logic o_ready,
	output audio_pkg::stereo_frame_t o_frame,
	output logic o_valid,
	input logic i_ready
);

	audio_pkg::stereo_frame_t mem [audio_pkg::fifo_depth];
	audio_pkg::fifo_ptr_t wr_ptr_q;
	audio_pkg::fifo_ptr_t rd_ptr_q;
	logic [audio_pkg::fifo_ptr_bits:0] occ_q;
	logic push;
	logic pop;

	// Top bit of the occupancy is set only when full
	assign o_ready = !occ_q[audio_pkg::fifo_ptr_bits];
	assign o_valid = occ_q != '0;
	assign o_frame = mem[rd_ptr_q];
	assign push = i_valid && o_ready;
	assign pop = o_valid && i_ready;

	always_ff @(posedge i_clock) begin
		if (push) begin
			mem[wr_ptr_q] <= i_frame;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			occ_q <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push, pop})
				2'b10: occ_q <= occ_q + 1'b1;
				2'b01: occ_q <= occ_q - 1'b1;
				default: occ_q <= occ_q;
			endcase
		end
	end

endmodule

/* rtl/channel_fetch.sv */
/*
 DMA sequencer for one audio channel.
 A start pulse loads base and word count; words are then requested one
 at a time while the FIFO has room, and each answer is pushed as a frame.
*/

`timescale 1ns/100ps

module channel_fetch (
	input logic i_clock,
	input logic i_rst_n,
	input audio_pkg::chan_setup_t i_setup,
	output audio_pkg::dma_req_t o_req,
	input logic i_grant_done,
	input audio_pkg::data_t i_dma_rdata,
	output audio_pkg::stereo_frame_t o_frame,
	output logic o_frame_valid,
	input logic i_frame_ready,
	output logic o_active
);

	audio_pkg::addr_t addr_q;
	audio_pkg::count_t count_q;
	logic drop_q;

	// An answer to a request issued before a restart is thrown away
	assign o_frame = audio_pkg::stereo_frame_t'(i_dma_rdata);
	assign o_frame_valid = i_grant_done && !drop_q;
	assign o_active = (count_q != '0) || o_req.request;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_req.request <= 1'b0;
			count_q <= '0;
			drop_q <= 1'b0;
		end else begin
			if (i_grant_done) begin
				o_req.request <= 1'b0;
				drop_q <= 1'b0;
				if (!drop_q) begin
					addr_q <= addr_q + audio_pkg::addr_t'(4);
					count_q <= count_q - 1'b1;
				end
			end else if (!o_req.request && count_q != '0 && i_frame_ready &&
				!i_setup.start) begin
				o_req.request <= 1'b1;
				o_req.address <= addr_q;
			end
			// Restart replaces whatever is running
			if (i_setup.start) begin
				addr_q <= i_setup.address;
				count_q <= i_setup.count;
				drop_q <= o_req.request && !i_grant_done;
			end
		end
	end

endmodule

/* rtl/dma_arbiter.sv */
/*
 Round-robin owner of the single DMA bus master.
 Picks one requesting channel while the bus is idle, holds its address
 until the host answers, then pulses that channel's grant-done.
*/

`timescale 1ns/100ps

module dma_arbiter (
	input logic i_clock,
	input logic i_rst_n,
	input audio_pkg::dma_req_t i_req [audio_pkg::num_channels],
	output logic [audio_pkg::num_channels-1:0] o_grant_done,
	output audio_pkg::dma_req_t o_dma,
	input logic i_dma_ready
);

	audio_pkg::chan_idx_t ptr_q;
	audio_pkg::chan_idx_t owner_q;
	audio_pkg::chan_idx_t idx;
	audio_pkg::chan_idx_t sel;
	logic found;

	// Scan starts at the channel after the last one served
	always_comb begin
		found = 1'b0;
		sel = ptr_q;
		idx = ptr_q;
		for (int i = 0; i < audio_pkg::num_channels; i++) begin
			idx = ptr_q + audio_pkg::chan_idx_t'(i);
			if (!found && i_req[idx].request) begin
				found = 1'b1;
				sel = idx;
			end
		end
	end

	always_comb begin
		o_grant_done = '0;
		if (o_dma.request && i_dma_ready) begin
			o_grant_done[owner_q] = 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_dma.request <= 1'b0;
			owner_q <= '0;
			ptr_q <= '0;
		end else if (o_dma.request) begin
			if (i_dma_ready) begin
				o_dma.request <= 1'b0;
				ptr_q <= owner_q + 1'b1;
			end
		end else if (found) begin
			o_dma.request <= 1'b1;
			o_dma.address <= i_req[sel].address;
			owner_q <= sel;
		end
	end

endmodule

/* rtl/audio_regs.sv */
/*
 CPU register block of the audio controller.
 Decodes the request/ready access into per-channel base, count and
 volume registers, pulses a channel start on a count write and
 returns the busy word on a read of the busy address.
*/

`timescale 1ns/100ps

module audio_regs (
	input logic i_clock,
	input logic i_rst_n,
	input audio_pkg::cpu_req_t i_cpu,
	output audio_pkg::data_t o_cpu_rdata,
	output logic o_cpu_ready,
	output audio_pkg::chan_setup_t o_setup [audio_pkg::num_channels],
	output audio_pkg::volume_t o_volume [audio_pkg::num_channels],
	input logic [audio_pkg::num_channels-1:0] i_fetch_active,
	input logic [audio_pkg::num_channels-1:0] i_fifo_valid
);

	audio_pkg::cpu_addr_t reg_chan;
	logic [audio_pkg::reg_off_bits-1:0] reg_off;
	logic access;
	logic wr_stb;
	logic [audio_pkg::num_channels-1:0] busy;
	logic [audio_pkg::num_channels-1:0] start_q;
	audio_pkg::addr_t base_q [audio_pkg::num_channels];
	audio_pkg::count_t count_q [audio_pkg::num_channels];

	assign reg_chan = i_cpu.address >> audio_pkg::reg_off_bits;
	assign reg_off = i_cpu.address[audio_pkg::reg_off_bits-1:0];
	// First cycle of a new access
	assign access = i_cpu.request && !o_cpu_ready;
	assign wr_stb = access && i_cpu.rw;
	assign busy = i_fetch_active | i_fifo_valid;

	always_comb begin
		for (int i = 0; i < audio_pkg::num_channels; i++) begin
			o_setup[i].start = start_q[i];
			o_setup[i].address = base_q[i];
			o_setup[i].count = count_q[i];
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_cpu_ready <= 1'b0;
			start_q <= '0;
			for (int i = 0; i < audio_pkg::num_channels; i++) begin
				o_volume[i] <= '0;
			end
		end else begin
			start_q <= '0;
			if (access) begin
				o_cpu_ready <= 1'b1;
			end else if (!i_cpu.request) begin
				o_cpu_ready <= 1'b0;
			end
			for (int i = 0; i < audio_pkg::num_channels; i++) begin
				if (wr_stb && reg_chan == audio_pkg::cpu_addr_t'(i)) begin
					if (reg_off == audio_pkg::reg_count) begin
						start_q[i] <= 1'b1;
					end
					if (reg_off == audio_pkg::reg_volume) begin
						o_volume[i] <= i_cpu.wdata[audio_pkg::volume_width-1:0];
					end
				end
			end
		end
	end

	// Setup payload and read data
	always_ff @(posedge i_clock) begin
		if (access && !i_cpu.rw) begin
			o_cpu_rdata <= (i_cpu.address == audio_pkg::reg_busy) ?
				audio_pkg::data_t'(busy) : '0;
		end
		for (int i = 0; i < audio_pkg::num_channels; i++) begin
			if (wr_stb && reg_chan == audio_pkg::cpu_addr_t'(i)) begin
				if (reg_off == audio_pkg::reg_address) begin
					base_q[i] <= i_cpu.wdata;
				end
				if (reg_off == audio_pkg::reg_count) begin
					count_q[i] <= i_cpu.wdata[audio_pkg::count_width-1:0];
				end
			end
		end
	end

endmodule

/* rtl/audio_pkg.sv */
/*
 Shared types and constants for the audio playback controller.
 Holds the channel count, the register map and the packed structs
 that travel between the CPU port, the DMA path and the mixer.
*/

package audio_pkg;

	localparam int num_channels = 4;
	localparam int fifo_depth = 4;
	localparam int sample_width = 16;
	localparam int volume_width = 4;
	localparam int addr_width = 32;
	localparam int data_width = 32;
	localparam int count_width = 24;
	localparam int cpu_addr_width = 8;
	localparam int chan_bits = $clog2(num_channels);
	localparam int fifo_ptr_bits = $clog2(fifo_depth);

	// Register map, one block of reg_stride addresses per channel
	localparam int reg_stride = 4;
	localparam int reg_off_bits = $clog2(reg_stride);
	localparam logic [reg_off_bits-1:0] reg_address = 0;
	localparam logic [reg_off_bits-1:0] reg_count = 1;
	localparam logic [reg_off_bits-1:0] reg_volume = 2;
	localparam logic [cpu_addr_width-1:0] reg_busy = 8'h01;

	typedef logic [chan_bits-1:0] chan_idx_t;
	typedef logic [fifo_ptr_bits-1:0] fifo_ptr_t;
	typedef logic [volume_width-1:0] volume_t;
	typedef logic [addr_width-1:0] addr_t;
	typedef logic [data_width-1:0] data_t;
	typedef logic [count_width-1:0] count_t;
	typedef logic [cpu_addr_width-1:0] cpu_addr_t;
	typedef logic signed [sample_width-1:0] sample_t;

	typedef struct packed {
		logic request;
		logic rw;
		cpu_addr_t address;
		data_t wdata;
	} cpu_req_t;

	typedef struct packed {
		logic start;
		addr_t address;
		count_t count;
	} chan_setup_t;

	// Left in the upper half of a DMA word
	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_frame_t;

	typedef struct packed {
		logic request;
		addr_t address;
	} dma_req_t;

endpackage
